//--- include/fma16_settings.svh
// fma16 build parameters sizing the alignment vector and its guard bits
`ifndef FMA16_SETTINGS_SVH
`define FMA16_SETTINGS_SVH

// msb index of the aligned sum vector
// product lsb sits at END_BITS, product point 20 bits above it,
// the rest is headroom for a z larger than the product
`define FMA16_VEC_SIZE 48

// guard bits kept below the product lsb
// wide enough that a cancelling z never runs past bit 0
`define FMA16_END_BITS 12

`endif

//--- hw/fma16_pkg.sv
// fma16 datapath types shared by the pipeline blocks and the testbench
`include "fma16_settings.svh"

package fma16_pkg;

    // operand and result word, sign | exponent | fraction
    typedef logic [15:0] half_t;

    typedef logic [4:0] exp_t;           // biased operand exponent
    typedef logic [9:0] man_t;           // stored fraction, hidden one dropped

    // unbiased product exponent, (xe-15)+(ye-15) spans -30..30
    typedef logic signed [5:0] pexp_t;

    // exact 11x11 significand product, point between bits 20 and 19
    typedef logic [21:0] prod_t;

    // aligned vector for z, product and their sum
    typedef logic [`FMA16_VEC_SIZE:0] sum_t;

    typedef logic signed [6:0] acnt_t;   // pe minus unbiased ze
    typedef logic signed [7:0] shift_t;  // leading one distance from the point

endpackage

//--- hw/fma16_unpack.sv
// fma16 operand unpack with zero flush and the exact significand product
module fma16_unpack (
    input  fma16_pkg::half_t x,
    input  fma16_pkg::half_t y,
    input  fma16_pkg::half_t z,
    output logic             xs, ys, zs,
    output fma16_pkg::exp_t  xe, ye, ze,
    output fma16_pkg::man_t  zm,
    output fma16_pkg::pexp_t pe,
    output fma16_pkg::prod_t mid_pm,
    output logic             x_zero, y_zero, z_zero
);
    import fma16_pkg::*;

    man_t xm, ym;   // multiplicand fractions, only needed for the product

    // field split
    assign {xs, xe, xm} = x;
    assign {ys, ye, ym} = y;
    assign {zs, ze, zm} = z;   // z fraction goes straight on to alignment

    // exponent field 0 covers true zero and subnormals
    // subnormals are flushed, so the fraction is ignored here
    assign x_zero = (xe == '0);
    assign y_zero = (ye == '0);
    assign z_zero = (ze == '0);

    // unbiased product exponent (xe-15)+(ye-15)
    // 6 bit wraparound gives the two's complement value directly
    assign pe = pexp_t'({1'b0, xe} + {1'b0, ye} - 6'd30);

    // hidden ones restored, 1.x * 1.y lands in [1,4)
    // two integer bits on top, 20 fraction bits below
    assign mid_pm = prod_t'({1'b1, xm}) * prod_t'({1'b1, ym});

endmodule

//--- hw/fma16_sum.sv
// fma16 magnitude adder, add on equal signs, larger minus smaller otherwise
`include "fma16_settings.svh"

module fma16_sum #(
    parameter int VEC_SIZE = `FMA16_VEC_SIZE
) (
    input  fma16_pkg::sum_t pm,                 // aligned product
    input  fma16_pkg::sum_t am,                 // aligned z
    input  logic            product_greater,
    input  logic            diff_sign,          // effective subtraction
    output fma16_pkg::sum_t sm
);
    import fma16_pkg::*;

    sum_t                larger, smaller;       // operands ordered by size
    logic [VEC_SIZE+1:0] add_full;              // sum with carry bit

    assign larger  = product_greater ? pm : am;
    assign smaller = product_greater ? am : pm;

    assign add_full = {1'b0, pm} + {1'b0, am};

    // result is always a magnitude, the sign is picked upstream
    assign sm = diff_sign ? (larger - smaller) : add_full[VEC_SIZE:0];

    // z tops out at the msb with its lsb above the product msb,
    // so an add never spills past the vector
    always_comb begin
        assert #0 (diff_sign || !add_full[VEC_SIZE+1])
            else $error("fma16_sum carry out of the aligned vector");
    end

endmodule

//--- hw/fma16_mshifter.sv
// fma16 leading-one detector giving the signed normalizing shift
`include "fma16_settings.svh"

module fma16_mshifter #(
    parameter int VEC_SIZE = `FMA16_VEC_SIZE,
    parameter int END_BITS = `FMA16_END_BITS
) (
    input  fma16_pkg::sum_t   sm,
    output fma16_pkg::shift_t m_shift
);
    import fma16_pkg::*;

    localparam int POINT = END_BITS + 20;   // bit weighted 2^0 in the vector

    shift_t lead;                           // index of the highest set bit

    // priority search, walking upward so the top one wins
    always_comb begin
        lead = '0;
        for (int i = 0; i <= VEC_SIZE; i++) begin
            if (sm[i]) begin
                lead = shift_t'(i);
            end
        end
    end

    // > 0  sum grew above the point, shift right
    // < 0  cancellation, shift left
    // zero sum reports no shift
    assign m_shift = (sm == '0) ? '0 : lead - shift_t'(POINT);

    // alignment keeps every live bit inside the vector
    always_comb begin
        assert #0 ((m_shift >= -shift_t'(POINT)) &&
                   (m_shift <= shift_t'(VEC_SIZE - POINT)))
            else $error("fma16_mshifter shift outside the vector");
    end

endmodule

//--- hw/fma16_align_and_sum.sv
// fma16 z alignment against the product, sign pick, magnitude sum and shift detect
`include "fma16_settings.svh"

module fma16_align_and_sum #(
    parameter int VEC_SIZE = `FMA16_VEC_SIZE,
    parameter int END_BITS = `FMA16_END_BITS
) (
    input  logic              ps, zs,            // product and z signs
    input  fma16_pkg::pexp_t  pe,                // unbiased product exponent
    input  fma16_pkg::exp_t   ze,                // biased z exponent
    input  fma16_pkg::man_t   zm,
    input  fma16_pkg::prod_t  mid_pm,
    input  logic              x_zero, y_zero, z_zero,
    output fma16_pkg::sum_t   sm,                // magnitude of the sum
    output fma16_pkg::shift_t m_shift,
    output logic              ms, product_greater, z_visible
);
    import fma16_pkg::*;

    localparam int POINT   = END_BITS + 20;     // vector bit weighted 2^pe
    localparam int MAX_LSH = VEC_SIZE - POINT;  // headroom above the point

    logic                  prod_zero;
    acnt_t                 acnt, neg_acnt;      // pe - (ze-15) and its negation
    logic [6:0]            rsh, lsh;            // z shift amounts
    sum_t                  z_base;              // z, hidden one on the point
    logic [2*VEC_SIZE+1:0] z_wide;              // right shift with lost bits kept
    logic                  sticky;              // anything fell off the bottom
    sum_t                  am, pm;              // aligned z and product

    assign prod_zero = x_zero | y_zero;

    //////////////////////////////////////////////////////////////////////
    // alignment
    //////////////////////////////////////////////////////////////////////

    assign acnt     = acnt_t'({pe[5], pe} - ({2'b00, ze} - 7'd15));
    assign neg_acnt = -acnt;

    // zero product leaves z unshifted, the point then carries ze
    assign rsh = (prod_zero || acnt[6]) ? 7'd0 : acnt;

    // z far above the product pins at the msb
    // the product then lies wholly below the z lsb, only its presence counts
    always_comb begin
        if (prod_zero || !acnt[6])
            lsh = 7'd0;
        else if (neg_acnt > acnt_t'(MAX_LSH))
            lsh = 7'(MAX_LSH);
        else
            lsh = neg_acnt;
    end

    assign z_base = z_zero ? '0 : sum_t'({1'b1, zm}) << (POINT - 10);
    assign z_wide = {z_base, {(VEC_SIZE + 1){1'b0}}} >> rsh;
    assign sticky = |z_wide[VEC_SIZE:0];        // folded into bit 0

    assign am = (lsh != '0) ? (z_base << lsh)
                            : (z_wide[2*VEC_SIZE+1:VEC_SIZE+1] | sum_t'(sticky));
    assign pm = prod_zero ? '0 : sum_t'(mid_pm) << END_BITS;

    //////////////////////////////////////////////////////////////////////
    // sign and flags
    //////////////////////////////////////////////////////////////////////

    assign product_greater = (pm >= am);        // ties go to the product
    // 0 + 0 keeps the and of the signs, otherwise the larger magnitude wins
    assign ms = (prod_zero && z_zero) ? (ps & zs) : (product_greater ? ps : zs);
    assign z_visible = |am[VEC_SIZE:END_BITS];  // z reaches product precision

    fma16_sum #(
        .VEC_SIZE(VEC_SIZE)
    ) u_sum (
        .pm, .am,
        .product_greater,
        .diff_sign(ps ^ zs),
        .sm
    );

    fma16_mshifter #(
        .VEC_SIZE(VEC_SIZE),
        .END_BITS(END_BITS)
    ) u_mshifter (
        .sm,
        .m_shift
    );

    // a zero product must leave z untouched all the way through the adder
    always_comb begin
        assert #0 (!prod_zero || ((pm == '0) && (sm == am)))
            else $error("fma16_align_and_sum zero product disturbed the z path");
    end

endmodule

//--- hw/fma16_normalize.sv
// fma16 normalize, truncate and pack with overflow and underflow detection
`include "fma16_settings.svh"

module fma16_normalize #(
    parameter int VEC_SIZE = `FMA16_VEC_SIZE,
    parameter int END_BITS = `FMA16_END_BITS
) (
    input  fma16_pkg::sum_t   sm,
    input  fma16_pkg::shift_t m_shift,
    input  logic              ms,
    input  fma16_pkg::pexp_t  pe,
    input  fma16_pkg::exp_t   ze,
    input  logic              x_zero, y_zero, z_zero,
    output fma16_pkg::half_t  result,
    output logic              overflow, underflow
);
    import fma16_pkg::*;

    localparam int POINT   = END_BITS + 20;
    localparam int MAX_LSH = VEC_SIZE - POINT;  // same clamp as alignment

    logic              prod_zero, sum_zero;
    logic signed [9:0] zeu, z_floor, pe_w;      // widened exponents
    logic signed [9:0] ref_exp, res_be;         // point weight, biased result
    logic [7:0]        lsh;                     // lead one up to the msb
    sum_t              norm;
    man_t              frac;

    assign prod_zero = x_zero | y_zero;
    assign sum_zero  = (sm == '0);

    //////////////////////////////////////////////////////////////////////
    // exponent
    //////////////////////////////////////////////////////////////////////

    assign zeu     = $signed({5'b00000, ze}) - 10'sd15;
    assign z_floor = zeu - 10'(MAX_LSH);        // point weight when z is pinned
    assign pe_w    = {{4{pe[5]}}, pe};

    // larger of product and clamped z, z alone when the product is zero
    assign ref_exp = prod_zero ? zeu : ((pe_w > z_floor) ? pe_w : z_floor);
    assign res_be  = ref_exp + $signed({{2{m_shift[7]}}, m_shift}) + 10'sd15;

    // fraction, everything below the top 10 bits is dropped
    assign lsh  = 8'(MAX_LSH) - m_shift;
    assign norm = sm << lsh;
    assign frac = norm[VEC_SIZE-1 -: 10];

    //////////////////////////////////////////////////////////////////////
    // pack
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        overflow  = 1'b0;
        underflow = 1'b0;
        if (sum_zero) begin
            result = {(prod_zero && z_zero) ? ms : 1'b0, 15'b0};  // cancel gives +0
        end else if (res_be > 10'sd30) begin
            result   = {ms, 5'd30, 10'h3ff};    // saturate to largest finite
            overflow = 1'b1;
        end else if (res_be < 10'sd1) begin
            result    = {ms, 15'b0};            // below normal range, flush
            underflow = 1'b1;
        end else begin
            result = {ms, res_be[4:0], frac};
        end
    end

endmodule

//--- hw/fma16_top.sv
// fma16 two-stage pipelined half-precision fused multiply-add, round toward zero
`include "fma16_settings.svh"

module fma16_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  fma16_pkg::half_t x, y, z,
    output fma16_pkg::half_t result,
    output logic             result_valid, overflow, underflow
);
    import fma16_pkg::*;

    logic   xs, ys, zs, ms, product_greater, z_visible;   // stage one comb
    exp_t   ze;
    man_t   zm;
    pexp_t  pe;
    prod_t  mid_pm;
    logic   x_zero, y_zero, z_zero;
    sum_t   sm;
    shift_t m_shift;

    logic   s1_valid, s1_ms, s1_x_zero, s1_y_zero, s1_z_zero;   // stage one regs
    sum_t   s1_sm;
    shift_t s1_m_shift;
    pexp_t  s1_pe;
    exp_t   s1_ze;

    half_t  n_result;                                       // stage two comb
    logic   n_overflow, n_underflow;

    //////////////////////////////////////////////////////////////////////
    // stage one, unpack and align
    //////////////////////////////////////////////////////////////////////

    fma16_unpack u_unpack (
        .x, .y, .z,
        .xs, .ys, .zs,
        .xe(), .ye(), .ze,          // x and y exponents only feed pe
        .zm, .pe, .mid_pm,
        .x_zero, .y_zero, .z_zero
    );

    fma16_align_and_sum #(
        .VEC_SIZE(`FMA16_VEC_SIZE),
        .END_BITS(`FMA16_END_BITS)
    ) u_align_and_sum (
        .ps(xs ^ ys), .zs, .pe, .ze, .zm, .mid_pm,
        .x_zero, .y_zero, .z_zero,
        .sm, .m_shift, .ms, .product_greater, .z_visible
    );

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_sm      <= sm;
            s1_ms      <= ms;
            s1_m_shift <= m_shift;
            s1_pe      <= pe;
            s1_ze      <= ze;
            s1_x_zero  <= x_zero;
            s1_y_zero  <= y_zero;
            s1_z_zero  <= z_zero;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage two, normalize and pack
    //////////////////////////////////////////////////////////////////////

    fma16_normalize #(
        .VEC_SIZE(`FMA16_VEC_SIZE),
        .END_BITS(`FMA16_END_BITS)
    ) u_normalize (
        .sm(s1_sm), .m_shift(s1_m_shift), .ms(s1_ms),
        .pe(s1_pe), .ze(s1_ze),
        .x_zero(s1_x_zero), .y_zero(s1_y_zero), .z_zero(s1_z_zero),
        .result(n_result), .overflow(n_overflow), .underflow(n_underflow)
    );

    // valid line and output register, no stall anywhere
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
            result       <= '0;
            overflow     <= 1'b0;
            underflow    <= 1'b0;
        end else begin
            s1_valid     <= in_valid;
            result_valid <= s1_valid;
            if (s1_valid) begin
                result    <= n_result;
                overflow  <= n_overflow;
                underflow <= n_underflow;
            end
        end
    end

    // fixed two-stage latency
    a_valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid == $past(in_valid, 2));

    // a z living only in the guard bits never outweighs the product
    a_hidden_z: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !z_visible |-> product_greater);

endmodule

//--- verif/fma16_tb.sv
// fma16 testbench driving a table of operations back to back and scoring the pipeline
module fma16_tb;
    import fma16_pkg::*;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 3;
    localparam int DRIVE_DELAY  = 10;            // input skew after the rising edge
    localparam int LATENCY      = 2;             // two register stages
    localparam int NUM_FIXED    = 15;
    localparam int NUM_RANDOM   = 4;
    localparam int NUM_ENTRIES  = NUM_FIXED + NUM_RANDOM;

    typedef struct packed {
        half_t x;
        half_t y;
        half_t z;
        half_t res;                              // expected truncated result
        logic  ov;
        logic  uf;
    } entry_t;

    //////////////////////////////////////////////////////////////////////
    // hand-computed operations x*y+z truncated toward zero
    //////////////////////////////////////////////////////////////////////

    localparam entry_t TABLE [NUM_FIXED] = '{
        '{16'h3C00, 16'h3C00, 16'h3C00, 16'h4000, 1'b0, 1'b0},  // 1*1+1 = 2
        '{16'h3E00, 16'h4000, 16'h3800, 16'h4300, 1'b0, 1'b0},  // 1.5*2+0.5 = 3.5
        '{16'h4000, 16'h3C00, 16'hC200, 16'hBC00, 1'b0, 1'b0},  // 2*1-3 where z wins the sign
        '{16'h3C00, 16'h3C00, 16'hBC00, 16'h0000, 1'b0, 1'b0},  // exact cancel to +0
        '{16'h0000, 16'h4000, 16'h4500, 16'h4500, 1'b0, 1'b0},  // x zero passes z
        '{16'h8000, 16'h3C00, 16'hC000, 16'hC000, 1'b0, 1'b0},  // -0*1-2 = -2
        '{16'h8000, 16'h3C00, 16'h8000, 16'h8000, 1'b0, 1'b0},  // -0 + -0 stays -0
        '{16'h3E00, 16'h3E00, 16'h0001, 16'h4080, 1'b0, 1'b0},  // subnormal z flushed
        '{16'h0200, 16'h3C00, 16'h3C00, 16'h3C00, 1'b0, 1'b0},  // subnormal x flushed
        '{16'h3C00, 16'h3C00, 16'h0400, 16'h3C00, 1'b0, 1'b0},  // 1+2^-14 truncated
        '{16'h3C00, 16'h3C00, 16'h8400, 16'h3BFF, 1'b0, 1'b0},  // 1-2^-14 just below 1
        '{16'h7800, 16'h3C00, 16'h0401, 16'h7800, 1'b0, 1'b0},  // 2^15 plus a far z
        '{16'h7800, 16'h3C00, 16'h8401, 16'h77FF, 1'b0, 1'b0},  // far z borrows below 2^15
        '{16'h5C00, 16'h5C00, 16'h0000, 16'h7BFF, 1'b1, 1'b0},  // 256*256 saturates
        '{16'h1C00, 16'h1C00, 16'h0000, 16'h0000, 1'b0, 1'b1}   // 2^-16 flushes
    };

    logic   clk, arst_n, in_valid;
    half_t  x, y, z;
    half_t  result;
    logic   result_valid, overflow, underflow;

    entry_t entries [NUM_ENTRIES];
    entry_t exp_q [$];                           // expectations in issue order
    int     due_q [$];                           // cycle each result must show up
    entry_t cur;
    int     due;
    int     cyc     = 0;
    int     checked = 0;
    integer seed    = 62;

    fma16_top DUT (
        .clk, .arst_n, .in_valid,
        .x, .y, .z,
        .result, .result_valid, .overflow, .underflow
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;       // edge counter for latency checks

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_half(input string what, input half_t got, input half_t want);
        if (got !== want)
            stop_with_failure($sformatf("Fail %0t: %s is %h, expected %h (entry %0d)",
                                        $time, what, got, want, checked));
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want)
            stop_with_failure($sformatf("Fail %0t: %s is %b, expected %b (entry %0d)",
                                        $time, what, got, want, checked));
    endtask

    // fixed rows first and then random z behind a zero product so the answer is z itself
    task automatic load_entries;
        int    r;
        half_t zr;
        for (int i = 0; i < NUM_FIXED; i++) begin
            entries[i] = TABLE[i];
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r  = $random(seed);
            zr = {r[15], 5'(r[20:16] % 30) + 5'd1, r[9:0]};   // normal exponents only
            entries[NUM_FIXED + i] = '{(i % 2 == 0) ? 16'h0000 : 16'h8000, 16'h4000,
                                       zr, zr, 1'b0, 1'b0};
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        x        = '0;
        y        = '0;
        z        = '0;
        load_entries();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) arst_n = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            in_valid = 1'b1;                     // one new operation every cycle
            x        = entries[i].x;
            y        = entries[i].y;
            z        = entries[i].z;
            exp_q.push_back(entries[i]);
            due_q.push_back(cyc + LATENCY);
        end
        @(posedge clk);
        #(DRIVE_DELAY) in_valid = 1'b0;
        wait (checked == NUM_ENTRIES);
        repeat (3) @(posedge clk);               // no stray result after the last one
        $display("*** PASSED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // scoreboard sampled mid-cycle while outputs are steady
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (result_valid) begin
            if (exp_q.size() == 0)
                stop_with_failure("result_valid was high with no operation in flight");
            cur = exp_q.pop_front();
            due = due_q.pop_front();
            if (due != cyc)
                stop_with_failure($sformatf("Fail %0t: result in cycle %0d, expected %0d",
                                            $time, cyc, due));
            check_half("result", result, cur.res);
            check_flag("overflow", overflow, cur.ov);
            check_flag("underflow", underflow, cur.uf);
            checked++;
        end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
            stop_with_failure($sformatf("Fail %0t: no result in cycle %0d", $time, cyc));
        end
    end

    // table length plus reset plus slack
    initial begin
        #((NUM_ENTRIES + RESET_CYCLES + 10) * PERIOD);
        stop_with_failure("results stopped coming before all table entries were checked");
    end

endmodule

//--- sources.f
+incdir+include
hw/fma16_pkg.sv
hw/fma16_unpack.sv
hw/fma16_sum.sv
hw/fma16_mshifter.sv
hw/fma16_align_and_sum.sv
hw/fma16_normalize.sv
hw/fma16_top.sv
verif/fma16_tb.sv

//--- Makefile
# Verilator build for the fma16 testbench

VERILATOR ?= verilator
TOP       := fma16_tb
FILELIST  := sources.f
VFLAGS    := --timing --assert -j 0
BUILD     := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero when the testbench hits $fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
